// File: Bender.yml
package:
  name: vread_unit

export_include_dirs:
  - .

sources:
  - files:
      - vread_cfg_pkg.sv
      - vread_bus_pkg.sv
      - addr_gen.sv
      - bus_read_ctrl.sv
      - pingpong_buffer.sv
      - stream_out.sv
      - vread_unit.sv
  - target: simulation
    files:
      - tb_vread_unit.sv

// File: addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          run_i,
   input  wire vread_cfg_pkg::addr_t    start_i,
   input  wire vread_cfg_pkg::addr_t    incr_i,
   input  wire vread_cfg_pkg::addr_t    shift_i,
   input  wire vread_cfg_pkg::addr_t    iterations_i,
   input  wire vread_cfg_pkg::period_t  period_i,
   input  wire vread_cfg_pkg::period_t  duty_i,
   input  wire vread_cfg_pkg::delay_t   delay_i,
   input  wire                          ready_i,
   output logic                         valid_o,
   output vread_cfg_pkg::addr_t         addr_o,
   output logic                         done_o
);
   import vread_cfg_pkg::*;

   logic    active_q;
   logic    done_q;
   delay_t  delay_q;
   period_t per_q;
   addr_t   iter_q;
   addr_t   addr_q;
   addr_t   base_q;
   logic    in_duty;
   logic    accept;
   logic    last_in_duty;
   logic    last_iter;
   logic    per_wrap;
   logic    empty_cfg;

   assign in_duty      = per_q < duty_i;
   assign last_in_duty = per_q == duty_i - period_t'(1);
   assign last_iter    = iter_q == iterations_i - addr_t'(1);
   // a period shorter than the duty is stretched to the duty
   assign per_wrap     = (per_q == period_i - period_t'(1)) ||
                         (last_in_duty && (period_i <= duty_i));
   assign empty_cfg    = (duty_i == '0) || (iterations_i == '0);

   assign valid_o = active_q && (delay_q == '0) && in_duty;
   assign accept  = valid_o && ready_i;
   assign addr_o  = addr_q;
   assign done_o  = done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         done_q   <= 1'b0;
         delay_q  <= '0;
         per_q    <= '0;
         iter_q   <= '0;
      end else begin
         done_q <= 1'b0;
         if (run_i) begin
            active_q <= !empty_cfg;
            done_q   <= empty_cfg;
            delay_q  <= delay_i;
            per_q    <= '0;
            iter_q   <= '0;
         end else if (active_q) begin
            if (delay_q != '0) begin
               delay_q <= delay_q - delay_t'(1);
            end else if (!in_duty || ready_i) begin
               // stalled offers freeze the period position
               per_q <= per_wrap ? '0 : per_q + period_t'(1);
               if (in_duty && last_in_duty) begin
                  iter_q <= iter_q + addr_t'(1);
                  if (last_iter) begin
                     active_q <= 1'b0;
                     done_q   <= 1'b1;
                  end
               end
            end
         end
      end
   end

   // running address and base of the current iteration
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q <= start_i;
         base_q <= start_i;
      end else if (accept) begin
         if (last_in_duty) begin
            addr_q <= base_q + shift_i;
            base_q <= base_q + shift_i;
         end else begin
            addr_q <= addr_q + incr_i;
         end
      end
   end

endmodule

`default_nettype wire

// File: bus_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module bus_read_ctrl (
   input  wire                                clk,
   input  wire                                rst,
   input  wire                                run_i,
   input  wire                                read_enabled_i,
   input  wire vread_bus_pkg::bus_addr_t      ext_addr_i,
   input  wire vread_cfg_pkg::len_t           read_length_i,
   input  wire vread_cfg_pkg::period_t        read_per_i,
   input  wire vread_cfg_pkg::period_t        read_duty_i,
   input  wire vread_cfg_pkg::addr_t          read_incr_i,
   input  wire vread_cfg_pkg::addr_t          read_iter_i,
   input  wire vread_cfg_pkg::addr_t          read_shift_i,
   input  wire                                bus_ready_i,
   input  wire [`VREAD_BUS_DATA_W-1:0]        bus_rdata_i,
   input  wire                                bus_last_i,
   output logic                               bus_valid_o,
   output vread_bus_pkg::bus_addr_t           bus_addr_o,
   output vread_cfg_pkg::len_t                bus_len_o,
   output logic                               wr_en_o,
   output vread_cfg_pkg::addr_t               wr_addr_o,
   output vread_bus_pkg::bus_word_u           wr_data_o,
   output logic                               read_done_o
);
   import vread_cfg_pkg::*;

   logic  gen_run;
   logic  gen_valid;
   logic  xfer;
   addr_t gen_addr;
   logic  read_done_q;

   assign gen_run = run_i && read_enabled_i;

   // buffer write addresses for the incoming beats
   addr_gen u_read_gen (
      .clk          (clk),
      .rst          (rst),
      .run_i        (gen_run),
      .start_i      ('0),
      .incr_i       (read_incr_i),
      .shift_i      (read_shift_i),
      .iterations_i (read_iter_i),
      .period_i     (read_per_i),
      .duty_i       (read_duty_i),
      .delay_i      ('0),
      .ready_i      (xfer),
      .valid_o      (gen_valid),
      .addr_o       (gen_addr),
      .done_o       ()
   );

   assign bus_valid_o = gen_valid && !read_done_q;
   assign xfer        = bus_valid_o && bus_ready_i;
   assign bus_len_o   = read_length_i;

   // each accepted beat goes to the current generator address
   assign wr_en_o        = xfer;
   assign wr_addr_o      = gen_addr;
   assign wr_data_o.word = bus_rdata_i;

   assign read_done_o = read_done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         read_done_q <= 1'b1;
      end else if (run_i) begin
         read_done_q <= !read_enabled_i;
      end else if (xfer && bus_last_i) begin
         read_done_q <= 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bus_addr_o <= '0;
      end else if (gen_run) begin
         bus_addr_o <= ext_addr_i;
      end
   end

endmodule

`default_nettype wire

// File: pingpong_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module pingpong_buffer (
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            run_i,
   input  wire                            ping_pong_i,
   input  wire                            wr_en_i,
   input  wire vread_cfg_pkg::addr_t      wr_addr_i,
   input  wire vread_bus_pkg::bus_word_u  wr_data_i,
   input  wire                            rd_en_i,
   input  wire vread_cfg_pkg::addr_t      rd_addr_i,
   input  wire                            rd_bank_i,
   output vread_bus_pkg::bus_word_u       rd_data_o
);
   import vread_bus_pkg::*;

   logic                             bank_q;
   logic                             wr_bank;
   logic                             rd_bank;
   logic [`VREAD_WORD_ADDR_W:0]      wr_idx;
   logic [`VREAD_WORD_ADDR_W:0]      rd_idx;
   bus_word_u                        mem [`VREAD_BUF_WORDS];

   // bus side fills the bank the stream is not reading
   assign wr_bank = ping_pong_i ? !bank_q : wr_addr_i[`VREAD_ADDR_W-1];
   assign rd_bank = ping_pong_i ? bank_q : rd_bank_i;

   // word index inside the bank comes from the low address bits
   assign wr_idx = {wr_bank, wr_addr_i[`VREAD_WORD_ADDR_W-1:0]};
   assign rd_idx = {rd_bank, rd_addr_i[`VREAD_WORD_ADDR_W-1:0]};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q <= 1'b0;
      end else if (run_i) begin
         bank_q <= ping_pong_i ? !bank_q : 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_idx] <= wr_data_i;
      end
      if (rd_en_i) begin
         rd_data_o <= mem[rd_idx];
      end
   end

endmodule

`default_nettype wire

// File: stream_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module stream_out (
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            run_i,
   input  wire vread_cfg_pkg::addr_t      out_start_i,
   input  wire vread_cfg_pkg::addr_t      out_incr_i,
   input  wire vread_cfg_pkg::addr_t      out_shift_i,
   input  wire vread_cfg_pkg::addr_t      out_iter_i,
   input  wire vread_cfg_pkg::period_t    out_per_i,
   input  wire vread_cfg_pkg::period_t    out_duty_i,
   input  wire vread_cfg_pkg::delay_t     delay_i,
   input  wire vread_bus_pkg::bus_word_u  rd_data_i,
   output logic                           rd_en_o,
   output vread_cfg_pkg::addr_t           rd_addr_o,
   output logic                           rd_bank_o,
   output logic                           out_valid_o,
   output vread_bus_pkg::sample_t         out_data_o,
   output logic                           output_done_o
);
   import vread_cfg_pkg::*;

   logic  gen_valid;
   logic  gen_done;
   addr_t sample_addr;
   logic  valid_q;
   logic  lane_q;
   logic  output_done_q;

   // sample addresses, no back-pressure on this side
   addr_gen u_out_gen (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .start_i      (out_start_i),
      .incr_i       (out_incr_i),
      .shift_i      (out_shift_i),
      .iterations_i (out_iter_i),
      .period_i     (out_per_i),
      .duty_i       (out_duty_i),
      .delay_i      (delay_i),
      .ready_i      (1'b1),
      .valid_o      (gen_valid),
      .addr_o       (sample_addr),
      .done_o       (gen_done)
   );

   // bank bit on top, lane bit at the bottom, word index between
   assign rd_en_o   = gen_valid;
   assign rd_bank_o = sample_addr[`VREAD_ADDR_W-1];
   assign rd_addr_o = {2'b00, sample_addr[`VREAD_ADDR_W-2:1]};

   // track the lane across the one-cycle buffer read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= gen_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (gen_valid) begin
         lane_q <= sample_addr[0];
      end
   end

   assign out_valid_o = valid_q;
   assign out_data_o  = rd_data_i.lane[lane_q];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         output_done_q <= 1'b1;
      end else if (run_i) begin
         output_done_q <= 1'b0;
      end else if (gen_done) begin
         output_done_q <= 1'b1;
      end
   end

   assign output_done_o = output_done_q;

endmodule

`default_nettype wire

// File: tb_vread_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module tb_vread_unit;
   import vread_cfg_pkg::*;
   import vread_bus_pkg::*;

   localparam int CLK_PERIOD      = 40;
   localparam int RESET_CYCLES    = 5;
   localparam int RUN_BUDGET      = 200;
   localparam int RUN_COUNT       = 10;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 8 + RUN_COUNT * (RUN_BUDGET + 2);

   logic                         clk, rst, run_i, ping_pong_i, read_enabled_i;
   bus_addr_t                    ext_addr_i;
   len_t                         read_length_i;
   period_t                      read_per_i, read_duty_i, out_per_i, out_duty_i;
   addr_t                        read_incr_i, read_iter_i, read_shift_i;
   addr_t                        out_start_i, out_incr_i, out_shift_i, out_iter_i;
   delay_t                       delay_i;
   logic                         bus_ready_i, bus_last_i;
   logic [`VREAD_BUS_DATA_W-1:0] bus_rdata_i;
   logic                         bus_valid_o, out_valid_o, done_o;
   bus_addr_t                    bus_addr_o;
   len_t                         bus_len_o;
   sample_t                      out_data_o;

   // reference buffer contents and bank state
   logic [`VREAD_BUS_DATA_W-1:0] model_mem [`VREAD_BUF_WORDS];
   logic                         model_bank;
   logic [`VREAD_BUS_DATA_W-1:0] src_words [$];
   sample_t                      exp_q [$];
   sample_t                      got_q [$];
   int                           errors, tests_passed, tests_failed;

   vread_unit DUT (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("sim failed");
      $finish;
   end

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (got !== exp) begin
         $display("ERROR %s expected %h got %h", name, exp, got);
         errors++;
      end
   endtask

   task automatic flag_failure(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic finish_test(input string name, input int err0);
      if (errors == err0) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: fail with %0d errors", name, errors - err0);
      end
   endtask

   // address(i, j) = start + i*shift + j*incr
   function automatic addr_t loop_addr(addr_t start, addr_t shift, addr_t incr, int i, int j);
      return start + addr_t'(i) * shift + addr_t'(j) * incr;
   endfunction

   function automatic int write_index(addr_t w);
      if (ping_pong_i)
         return int'({!model_bank, w[7:0]});
      return int'({w[9], w[7:0]});
   endfunction

   function automatic sample_t expected_sample(addr_t s);
      int idx;
      idx = ping_pong_i ? int'({model_bank, s[8:1]}) : int'({s[9], s[8:1]});
      return s[0] ? model_mem[idx][31:16] : model_mem[idx][15:0];
   endfunction

   task automatic fill_source(input int n);
      src_words = {};
      repeat (n) src_words.push_back($urandom());
   endtask

   task automatic set_read(input bus_addr_t ext, input len_t len, input period_t per,
                           input period_t duty, input addr_t incr, input addr_t iter,
                           input addr_t shift);
      ext_addr_i    = ext;
      read_length_i = len;
      read_per_i    = per;
      read_duty_i   = duty;
      read_incr_i   = incr;
      read_iter_i   = iter;
      read_shift_i  = shift;
   endtask

   task automatic set_out(input addr_t start, input addr_t incr, input addr_t shift,
                          input addr_t iter, input period_t per, input period_t duty,
                          input delay_t delay);
      out_start_i = start;
      out_incr_i  = incr;
      out_shift_i = shift;
      out_iter_i  = iter;
      out_per_i   = per;
      out_duty_i  = duty;
      delay_i     = delay;
   endtask

   // one run: bus responder, stream monitor and done wait in one loop
   task automatic do_run(input bit random_ready, output int first_valid);
      addr_t wr_list [$];
      int    exp_cyc [$];
      int    got_cyc [$];
      addr_t s;
      int    beat, cyc, i, j, k;
      bit    done_seen;
      model_bank = ping_pong_i ? !model_bank : 1'b0;
      wr_list = {};
      exp_q = {};
      got_q = {};
      if (read_enabled_i)
         for (i = 0; i < int'(read_iter_i); i++)
            for (j = 0; j < int'(read_duty_i); j++)
               wr_list.push_back(loop_addr('0, read_shift_i, read_incr_i, i, j));
      for (i = 0; i < int'(out_iter_i); i++)
         for (j = 0; j < int'(out_duty_i); j++) begin
            s = loop_addr(out_start_i, out_shift_i, out_incr_i, i, j);
            exp_q.push_back(expected_sample(s));
            // address issued delay+1 cycles after run, sample one cycle later
            exp_cyc.push_back(int'(delay_i) + 2 + i * int'(out_per_i) + j);
         end
      first_valid = -1;
      beat = 0;
      done_seen = 1'b0;
      run_i = 1'b1;
      next_cycle();
      run_i = 1'b0;
      for (cyc = 1; cyc <= RUN_BUDGET && !done_seen; cyc++) begin
         bus_ready_i = random_ready ? ($urandom_range(3) != 0) : 1'b1;
         bus_rdata_i = (beat < src_words.size()) ? src_words[beat] : '0;
         bus_last_i  = (beat == int'(read_length_i));
         @(negedge clk);
         if (cyc == 1)
            check_val("done_o", 32'h0, done_o);
         if (bus_valid_o && !read_enabled_i)
            flag_failure("bus_valid_o went high while the read was disabled");
         if (bus_valid_o && bus_ready_i) begin
            check_val("bus_addr_o", ext_addr_i, bus_addr_o);
            check_val("bus_len_o", read_length_i, bus_len_o);
            if (beat < wr_list.size())
               model_mem[write_index(wr_list[beat])] = src_words[beat];
            else
               flag_failure("bus accepted more beats than the read pattern holds");
            beat++;
         end
         if (out_valid_o) begin
            if (first_valid < 0)
               first_valid = cyc;
            got_q.push_back(out_data_o);
            got_cyc.push_back(cyc);
         end
         done_seen = done_o;
         next_cycle();
      end
      if (!done_seen)
         flag_failure($sformatf("done_o did not return high within %0d cycles", RUN_BUDGET));
      if (read_enabled_i)
         check_val("bus beat count", int'(read_length_i) + 1, beat);
      check_val("out sample count", exp_q.size(), got_q.size());
      for (k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
         check_val("out_data_o", exp_q[k], got_q[k]);
         check_val("out_valid_o cycle", exp_cyc[k], got_cyc[k]);
      end
   endtask

   task automatic check_reset_state();
      int err0;
      err0 = errors;
      @(negedge clk);
      check_val("done_o", 32'h1, done_o);
      check_val("bus_valid_o", 32'h0, bus_valid_o);
      check_val("out_valid_o", 32'h0, out_valid_o);
      next_cycle();
      finish_test("reset state", err0);
   endtask

   task automatic linear_read_stream();
      int err0, first;
      err0 = errors;
      ping_pong_i = 1'b0;
      fill_source(8);
      read_enabled_i = 1'b1;
      set_read(32'h8000_1000, 8'd7, 8'd8, 8'd8, 10'd1, 10'd1, 10'd0);
      set_out(10'd0, 10'd1, 10'd0, 10'd0, 8'd16, 8'd16, 7'd0);
      do_run(1'b0, first);
      read_enabled_i = 1'b0;
      set_out(10'd0, 10'd1, 10'd0, 10'd1, 8'd16, 8'd16, 7'd0);
      do_run(1'b0, first);
      finish_test("linear read then stream", err0);
   endtask

   task automatic strided_delayed_output();
      int err0, first;
      err0 = errors;
      fill_source(32);
      read_enabled_i = 1'b1;
      set_read(32'h0000_4000, 8'd31, 8'd32, 8'd32, 10'd1, 10'd1, 10'd0);
      set_out(10'd0, 10'd1, 10'd0, 10'd0, 8'd1, 8'd1, 7'd0);
      do_run(1'b0, first);
      read_enabled_i = 1'b0;
      // gaps of two cycles per period, four iterations apart by ten
      set_out(10'd3, 10'd2, 10'd10, 10'd4, 8'd5, 8'd3, 7'd5);
      do_run(1'b0, first);
      check_val("first out_valid_o cycle", 32'd7, first);
      finish_test("strided and delayed output", err0);
   endtask

   task automatic bus_back_pressure();
      int err0, first;
      err0 = errors;
      fill_source(12);
      read_enabled_i = 1'b1;
      set_read(32'h2000_0040, 8'd11, 8'd4, 8'd2, 10'd1, 10'd6, 10'd3);
      set_out(10'd0, 10'd1, 10'd0, 10'd0, 8'd1, 8'd1, 7'd0);
      do_run(1'b1, first);
      read_enabled_i = 1'b0;
      set_out(10'd0, 10'd1, 10'd0, 10'd1, 8'd36, 8'd36, 7'd0);
      do_run(1'b0, first);
      finish_test("bus back-pressure", err0);
   endtask

   task automatic ping_pong_swap();
      int err0, first;
      err0 = errors;
      ping_pong_i = 1'b1;
      fill_source(8);
      read_enabled_i = 1'b1;
      set_read(32'h0000_0100, 8'd7, 8'd8, 8'd8, 10'd1, 10'd1, 10'd0);
      set_out(10'd0, 10'd1, 10'd0, 10'd0, 8'd1, 8'd1, 7'd0);
      do_run(1'b0, first);
      // new data in while the previous run's data goes out
      fill_source(8);
      ext_addr_i = 32'h0000_0200;
      set_out(10'd0, 10'd1, 10'd0, 10'd1, 8'd16, 8'd16, 7'd0);
      do_run(1'b1, first);
      read_enabled_i = 1'b0;
      do_run(1'b0, first);
      finish_test("ping-pong", err0);
   endtask

   task automatic read_disabled_run();
      int err0, first;
      err0 = errors;
      ping_pong_i = 1'b0;
      read_enabled_i = 1'b0;
      set_out(10'd0, 10'd1, 10'd4, 10'd2, 8'd6, 8'd4, 7'd3);
      do_run(1'b0, first);
      finish_test("read disabled", err0);
   endtask

   initial begin
      void'($urandom(76823));
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      model_bank = 1'b0;
      clk = 1'b0;
      rst = 1'b1;
      run_i = 1'b0;
      ping_pong_i = 1'b0;
      read_enabled_i = 1'b0;
      set_read('0, '0, '0, '0, '0, '0, '0);
      set_out('0, '0, '0, '0, '0, '0, '0);
      bus_ready_i = 1'b0;
      bus_rdata_i = '0;
      bus_last_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst = 1'b0;
      check_reset_state();
      linear_read_stream();
      strided_delayed_output();
      bus_back_pressure();
      ping_pong_swap();
      read_disabled_run();
      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vread_bus_pkg.sv
`default_nettype none

`include "vread_defs.svh"

package vread_bus_pkg;

   // external byte address of a burst
   typedef logic [`VREAD_BUS_ADDR_W-1:0] bus_addr_t;

   // one sample on the output stream
   typedef logic [`VREAD_DATA_W-1:0] sample_t;

   // a bus word, written whole into the buffer and read back by lane
   // lane 0 is the low half
   typedef union packed {
      logic [`VREAD_BUS_DATA_W-1:0] word;
      sample_t [1:0]                lane;
   } bus_word_u;

endpackage

`default_nettype wire

// File: vread_cfg_pkg.sv
`default_nettype none

`include "vread_defs.svh"

package vread_cfg_pkg;

   // buffer address, also used for strides and iteration counts
   typedef logic [`VREAD_ADDR_W-1:0] addr_t;

   // inner loop period and duty
   typedef logic [`VREAD_PERIOD_W-1:0] period_t;

   // cycles to wait before the first address
   typedef logic [`VREAD_DELAY_W-1:0] delay_t;

   // burst length minus one
   typedef logic [`VREAD_LEN_W-1:0] len_t;

endpackage

`default_nettype wire

// File: vread_defs.svh
`ifndef VREAD_DEFS_SVH
`define VREAD_DEFS_SVH

// buffer sample address, top bit selects the bank
`define VREAD_ADDR_W 10

// period and duty counters
`define VREAD_PERIOD_W 8

// output start delay
`define VREAD_DELAY_W 7

// burst length as sent on the bus (beats minus one)
`define VREAD_LEN_W 8

// external bus
`define VREAD_BUS_ADDR_W 32
`define VREAD_BUS_DATA_W 32

// one output sample, two per bus word
`define VREAD_DATA_W 16

// word index inside one bank, and total buffer depth in words
`define VREAD_WORD_ADDR_W (`VREAD_ADDR_W - 2)
`define VREAD_BUF_WORDS (1 << (`VREAD_ADDR_W - 1))

`endif

// File: vread_unit.f
+incdir+.
vread_cfg_pkg.sv
vread_bus_pkg.sv
addr_gen.sv
bus_read_ctrl.sv
pingpong_buffer.sv
stream_out.sv
vread_unit.sv
tb_vread_unit.sv

// File: vread_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defs.svh"

module vread_unit (
   input  wire                                clk,
   input  wire                                rst,
   input  wire                                run_i,
   input  wire                                ping_pong_i,
   input  wire                                read_enabled_i,
   input  wire vread_bus_pkg::bus_addr_t      ext_addr_i,
   input  wire vread_cfg_pkg::len_t           read_length_i,
   input  wire vread_cfg_pkg::period_t        read_per_i,
   input  wire vread_cfg_pkg::period_t        read_duty_i,
   input  wire vread_cfg_pkg::addr_t          read_incr_i,
   input  wire vread_cfg_pkg::addr_t          read_iter_i,
   input  wire vread_cfg_pkg::addr_t          read_shift_i,
   input  wire vread_cfg_pkg::addr_t          out_start_i,
   input  wire vread_cfg_pkg::addr_t          out_incr_i,
   input  wire vread_cfg_pkg::addr_t          out_shift_i,
   input  wire vread_cfg_pkg::addr_t          out_iter_i,
   input  wire vread_cfg_pkg::period_t        out_per_i,
   input  wire vread_cfg_pkg::period_t        out_duty_i,
   input  wire vread_cfg_pkg::delay_t         delay_i,
   output logic                               bus_valid_o,
   input  wire                                bus_ready_i,
   output vread_bus_pkg::bus_addr_t           bus_addr_o,
   output vread_cfg_pkg::len_t                bus_len_o,
   input  wire [`VREAD_BUS_DATA_W-1:0]        bus_rdata_i,
   input  wire                                bus_last_i,
   output logic                               out_valid_o,
   output vread_bus_pkg::sample_t             out_data_o,
   output logic                               done_o
);
   import vread_cfg_pkg::*;
   import vread_bus_pkg::*;

   logic      wr_en;
   addr_t     wr_addr;
   bus_word_u wr_data;
   logic      rd_en;
   addr_t     rd_addr;
   logic      rd_bank;
   bus_word_u rd_data;
   logic      read_done;
   logic      output_done;

   bus_read_ctrl u_bus_read_ctrl (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i),
      .read_enabled_i (read_enabled_i),
      .ext_addr_i     (ext_addr_i),
      .read_length_i  (read_length_i),
      .read_per_i     (read_per_i),
      .read_duty_i    (read_duty_i),
      .read_incr_i    (read_incr_i),
      .read_iter_i    (read_iter_i),
      .read_shift_i   (read_shift_i),
      .bus_ready_i    (bus_ready_i),
      .bus_rdata_i    (bus_rdata_i),
      .bus_last_i     (bus_last_i),
      .bus_valid_o    (bus_valid_o),
      .bus_addr_o     (bus_addr_o),
      .bus_len_o      (bus_len_o),
      .wr_en_o        (wr_en),
      .wr_addr_o      (wr_addr),
      .wr_data_o      (wr_data),
      .read_done_o    (read_done)
   );

   pingpong_buffer u_buffer (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .ping_pong_i (ping_pong_i),
      .wr_en_i     (wr_en),
      .wr_addr_i   (wr_addr),
      .wr_data_i   (wr_data),
      .rd_en_i     (rd_en),
      .rd_addr_i   (rd_addr),
      .rd_bank_i   (rd_bank),
      .rd_data_o   (rd_data)
   );

   stream_out u_stream_out (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .out_start_i   (out_start_i),
      .out_incr_i    (out_incr_i),
      .out_shift_i   (out_shift_i),
      .out_iter_i    (out_iter_i),
      .out_per_i     (out_per_i),
      .out_duty_i    (out_duty_i),
      .delay_i       (delay_i),
      .rd_data_i     (rd_data),
      .rd_en_o       (rd_en),
      .rd_addr_o     (rd_addr),
      .rd_bank_o     (rd_bank),
      .out_valid_o   (out_valid_o),
      .out_data_o    (out_data_o),
      .output_done_o (output_done)
   );

   // both sides idle
   assign done_o = read_done && output_done;

endmodule

`default_nettype wire
